//--- design/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// data and address width
`define LSU_XLEN 32

// transaction id width
`define LSU_ID_BITS 3

// register stages on the load and store result paths
`define LSU_RESULT_PIPE_DEPTH 1

// entries in the request buffer
`define LSU_BUF_DEPTH 2

`endif

//--- design/lsu_pkg.sv
`include "lsu_defines.svh"

package lsu_pkg;

    // ----------------------------------------------------------------------
    // enums
    // ----------------------------------------------------------------------
    typedef enum logic [3:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW
    } lsu_op_e;

    typedef enum logic [0:0] {
        LOAD,
        STORE
    } lsu_unit_e;

    // subset of the RISC-V exception codes
    typedef enum logic [3:0] {
        LD_ADDR_MISALIGNED = 4'd4,
        ST_ADDR_MISALIGNED = 4'd6
    } exc_cause_e;

    // ----------------------------------------------------------------------
    // structs
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic                  valid;
        exc_cause_e            cause;
        logic [`LSU_XLEN-1:0]  tval;
    } exc_t;

    // one queued request, fully decoded by the AGU
    typedef struct packed {
        lsu_unit_e                unit;
        lsu_op_e                  op;
        logic [`LSU_XLEN-1:0]     addr;
        logic [`LSU_XLEN-1:0]     wdata;
        logic [3:0]               be;
        logic                     misaligned;
        logic [`LSU_ID_BITS-1:0]  trans_id;
    } lsu_req_t;

    typedef struct packed {
        logic                     valid;
        logic [`LSU_ID_BITS-1:0]  trans_id;
        logic [`LSU_XLEN-1:0]     data;
        exc_t                     ex;
    } lsu_result_t;

    // addr holds the word address, byte address >> 2
    typedef struct packed {
        logic                  req;
        logic                  we;
        logic [`LSU_XLEN-1:0]  addr;
        logic [3:0]            be;
        logic [`LSU_XLEN-1:0]  wdata;
    } mem_req_t;

endpackage

//--- design/lsu_agu.sv
`include "lsu_defines.svh"

module lsu_agu import lsu_pkg::*; (
    input  logic [`LSU_XLEN-1:0]     operand_a_i,
    input  logic [`LSU_XLEN-1:0]     imm_i,
    input  logic [`LSU_XLEN-1:0]     operand_b_i,
    input  lsu_op_e                  op_i,
    input  logic [`LSU_ID_BITS-1:0]  trans_id_i,
    output lsu_req_t                 req_o
);

    logic [`LSU_XLEN-1:0] addr;
    logic [1:0]           size;
    lsu_unit_e            unit;
    logic [3:0]           be;
    logic                 misaligned;

    // physical address, no overflow check
    assign addr = operand_a_i + imm_i;

    // ----------------------------------------------------------------------
    // opcode decode
    // ----------------------------------------------------------------------
    // size: 0 byte, 1 halfword, 2 word
    always_comb begin
        unit = LOAD;
        size = 2'd2;
        unique case (op_i)
            LB, LBU: size = 2'd0;
            LH, LHU: size = 2'd1;
            LW:      size = 2'd2;
            SB: begin
                unit = STORE;
                size = 2'd0;
            end
            SH: begin
                unit = STORE;
                size = 2'd1;
            end
            SW: begin
                unit = STORE;
                size = 2'd2;
            end
            default: ;
        endcase
    end

    // byte enables and alignment
    always_comb begin
        unique case (size)
            2'd0:    be = 4'b0001 << addr[1:0];
            2'd1:    be = 4'b0011 << addr[1:0];
            default: be = 4'b1111;
        endcase
        misaligned = ((size == 2'd1) && addr[0]) ||
                     ((size == 2'd2) && (addr[1:0] != 2'b00));
    end

    always_comb begin
        req_o            = '0;
        req_o.unit       = unit;
        req_o.op         = op_i;
        req_o.addr       = addr;
        req_o.wdata      = operand_b_i;
        req_o.be         = be;
        req_o.misaligned = misaligned;
        req_o.trans_id   = trans_id_i;
    end

endmodule

//--- design/lsu_req_buffer.sv
`include "lsu_defines.svh"

module lsu_req_buffer import lsu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    input  logic      push_i,
    input  lsu_req_t  req_i,
    input  logic      pop_i,
    output lsu_req_t  head_o,
    output logic      head_valid_o,
    output logic      ready_o
);

    localparam int unsigned DEPTH   = `LSU_BUF_DEPTH;
    localparam int unsigned PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned COUNT_W = $clog2(DEPTH + 1);

    lsu_req_t             mem_q [DEPTH];
    logic [PTR_W-1:0]     wr_ptr_q;
    logic [PTR_W-1:0]     rd_ptr_q;
    logic [COUNT_W-1:0]   count_q;
    logic                 push_ok;
    logic                 pop_ok;

    assign ready_o      = (count_q != COUNT_W'(DEPTH));
    assign head_valid_o = (count_q != '0);
    // no fall-through, head only from storage
    assign head_o       = mem_q[rd_ptr_q];

    assign push_ok = push_i && ready_o && !flush_i;
    assign pop_ok  = pop_i && head_valid_o && !flush_i;

    // ----------------------------------------------------------------------
    // pointers and fill level
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            unique case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= req_i;
        end
    end

endmodule

//--- design/lsu_load_unit.sv
`include "lsu_defines.svh"

module lsu_load_unit import lsu_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  logic                  valid_i,
    input  lsu_req_t              req_i,
    output logic                  pop_o,
    output mem_req_t              mem_req_o,
    input  logic                  mem_gnt_i,
    input  logic [`LSU_XLEN-1:0]  mem_rdata_i,
    output lsu_result_t           result_o
);

    logic                  resp_valid_q;
    lsu_req_t              resp_q;
    logic [`LSU_XLEN-1:0]  shifted;
    logic [`LSU_XLEN-1:0]  ext_data;

    // ----------------------------------------------------------------------
    // request side
    // ----------------------------------------------------------------------
    // misaligned loads never reach memory
    always_comb begin
        mem_req_o       = '0;
        mem_req_o.req   = valid_i && !req_i.misaligned && !flush_i;
        mem_req_o.we    = 1'b0;
        mem_req_o.addr  = {2'b00, req_i.addr[`LSU_XLEN-1:2]};
        mem_req_o.be    = req_i.be;
    end

    assign pop_o = valid_i && !flush_i && (req_i.misaligned || mem_gnt_i);

    // ----------------------------------------------------------------------
    // response register
    // ----------------------------------------------------------------------
    // a granted load still returns after a flush
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= pop_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            resp_q <= req_i;
        end
    end

    // lane select and extension
    always_comb begin
        shifted = mem_rdata_i >> {resp_q.addr[1:0], 3'b000};
        unique case (resp_q.op)
            LB:      ext_data = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
            LBU:     ext_data = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
            LH:      ext_data = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
            LHU:     ext_data = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
            default: ext_data = mem_rdata_i;
        endcase
    end

    // data valid one cycle after the grant
    always_comb begin
        result_o          = '0;
        result_o.valid    = resp_valid_q;
        result_o.trans_id = resp_q.trans_id;
        result_o.ex.cause = LD_ADDR_MISALIGNED;
        if (resp_q.misaligned) begin
            result_o.ex.valid = 1'b1;
            result_o.ex.tval  = resp_q.addr;
        end else begin
            result_o.data = ext_data;
        end
    end

endmodule

//--- design/lsu_store_unit.sv
`include "lsu_defines.svh"

module lsu_store_unit import lsu_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_i,
    input  logic         valid_i,
    input  lsu_req_t     req_i,
    output logic         pop_o,
    output mem_req_t     mem_req_o,
    input  logic         mem_gnt_i,
    output lsu_result_t  result_o
);

    logic                     done_q;
    logic [`LSU_ID_BITS-1:0]  id_q;
    exc_t                     ex_q;
    logic [`LSU_XLEN-1:0]     wdata;

    // replicate into every lane, be picks the right one
    always_comb begin
        unique case (req_i.op)
            SB:      wdata = {4{req_i.wdata[7:0]}};
            SH:      wdata = {2{req_i.wdata[15:0]}};
            default: wdata = req_i.wdata;
        endcase
    end

    always_comb begin
        mem_req_o       = '0;
        mem_req_o.req   = valid_i && !req_i.misaligned && !flush_i;
        mem_req_o.we    = 1'b1;
        mem_req_o.addr  = {2'b00, req_i.addr[`LSU_XLEN-1:2]};
        mem_req_o.be    = req_i.be;
        mem_req_o.wdata = wdata;
    end

    assign pop_o = valid_i && !flush_i && (req_i.misaligned || mem_gnt_i);

    // ----------------------------------------------------------------------
    // completion
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            done_q <= 1'b0;
        end else begin
            done_q <= pop_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            id_q     <= req_i.trans_id;
            ex_q     <= '0;
            ex_q.cause <= ST_ADDR_MISALIGNED;
            if (req_i.misaligned) begin
                ex_q.valid <= 1'b1;
                ex_q.tval  <= req_i.addr;
            end
        end
    end

    assign result_o = '{valid: done_q, trans_id: id_q, data: '0, ex: ex_q};

endmodule

//--- design/lsu_top.sv
`include "lsu_defines.svh"

module lsu_top import lsu_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     valid_i,
    input  logic [`LSU_XLEN-1:0]     operand_a_i,
    input  logic [`LSU_XLEN-1:0]     imm_i,
    input  logic [`LSU_XLEN-1:0]     operand_b_i,
    input  lsu_op_e                  op_i,
    input  logic [`LSU_ID_BITS-1:0]  trans_id_i,
    output logic                     ready_o,
    output mem_req_t                 mem_req_o,
    input  logic                     mem_gnt_i,
    input  logic [`LSU_XLEN-1:0]     mem_rdata_i,
    output lsu_result_t              load_res_o,
    output lsu_result_t              store_res_o
);

    localparam int unsigned PIPE_DEPTH = `LSU_RESULT_PIPE_DEPTH;

    lsu_req_t     agu_req;
    lsu_req_t     head;
    logic         head_valid;
    logic         ld_valid, st_valid;
    logic         ld_pop, st_pop;
    mem_req_t     ld_mem_req, st_mem_req;
    lsu_result_t  unit_res [2];
    lsu_result_t  pipe_q [2][PIPE_DEPTH];

    lsu_agu i_agu (
        .operand_a_i (operand_a_i),
        .imm_i       (imm_i),
        .operand_b_i (operand_b_i),
        .op_i        (op_i),
        .trans_id_i  (trans_id_i),
        .req_o       (agu_req)
    );

    lsu_req_buffer i_req_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .push_i       (valid_i && ready_o),
        .req_i        (agu_req),
        .pop_i        (ld_pop || st_pop),
        .head_o       (head),
        .head_valid_o (head_valid),
        .ready_o      (ready_o)
    );

    // ----------------------------------------------------------------------
    // dispatch and memory port
    // ----------------------------------------------------------------------
    assign ld_valid = head_valid && (head.unit == LOAD);
    assign st_valid = head_valid && (head.unit == STORE);

    // at most one unit is active at a time
    assign mem_req_o = ld_valid ? ld_mem_req : st_mem_req;

    lsu_load_unit i_load_unit (
        .clk_i, .rst_ni, .flush_i, .mem_gnt_i, .mem_rdata_i,
        .valid_i   (ld_valid),
        .req_i     (head),
        .pop_o     (ld_pop),
        .mem_req_o (ld_mem_req),
        .result_o  (unit_res[0])
    );

    lsu_store_unit i_store_unit (
        .clk_i, .rst_ni, .flush_i, .mem_gnt_i,
        .valid_i   (st_valid),
        .req_i     (head),
        .pop_o     (st_pop),
        .mem_req_o (st_mem_req),
        .result_o  (unit_res[1])
    );

    // ----------------------------------------------------------------------
    // result pipelines, index 0 load and 1 store
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int p = 0; p < 2; p++) begin
                for (int s = 0; s < PIPE_DEPTH; s++) begin
                    pipe_q[p][s] <= '0;
                end
            end
        end else begin
            for (int p = 0; p < 2; p++) begin
                pipe_q[p][0] <= unit_res[p];
                for (int s = 1; s < PIPE_DEPTH; s++) begin
                    pipe_q[p][s] <= pipe_q[p][s-1];
                end
            end
        end
    end

    assign load_res_o  = pipe_q[0][PIPE_DEPTH-1];
    assign store_res_o = pipe_q[1][PIPE_DEPTH-1];

endmodule

//--- testbench/tb_lsu.sv
`include "lsu_defines.svh"

module tb_lsu import lsu_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS = 256;
    localparam int TIMEOUT   = 200;

    // one expected result, in acceptance order per stream
    typedef struct packed {
        logic [`LSU_ID_BITS-1:0]  trans_id;
        logic [`LSU_XLEN-1:0]     data;
        logic                     ex_valid;
        logic [3:0]               cause;
        logic [`LSU_XLEN-1:0]     tval;
    } expect_t;

    logic                     clk_i;
    logic                     rst_ni;
    logic                     flush_i;
    logic                     valid_i;
    logic [`LSU_XLEN-1:0]     operand_a_i;
    logic [`LSU_XLEN-1:0]     imm_i;
    logic [`LSU_XLEN-1:0]     operand_b_i;
    lsu_op_e                  op_i;
    logic [`LSU_ID_BITS-1:0]  trans_id_i;
    logic                     ready_o;
    mem_req_t                 mem_req_o;
    logic                     mem_gnt_i;
    logic [`LSU_XLEN-1:0]     mem_rdata_i;
    lsu_result_t              load_res_o;
    lsu_result_t              store_res_o;

    logic [31:0]  mem [MEM_WORDS];
    logic [31:0]  ref_mem [MEM_WORDS];
    expect_t      load_q [$];
    expect_t      store_q [$];
    int           errors;
    int           timeouts;
    int           write_count;
    int           writes_before;
    logic         gnt_hold;
    logic         mem_hit;
    mem_req_t     mem_cap;
    logic [2:0]   next_id;
    string        test_name;
    lsu_op_e      op;

    lsu_top lsu_top_inst (.*);

    always #5 clk_i = ~clk_i;

    // ------------------------------------------------------------------
    // checks and run control
    // ------------------------------------------------------------------
    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d check failures, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic compare_result(string kind, expect_t exp, lsu_result_t act);
        check_value({test_name, " ", kind, " id"}, exp.trans_id, act.trans_id);
        check_value({test_name, " ", kind, " data"}, exp.data, act.data);
        check_value({test_name, " ", kind, " ex valid"}, exp.ex_valid, act.ex.valid);
        if (exp.ex_valid) begin
            check_value({test_name, " ", kind, " cause"}, exp.cause, act.ex.cause);
            check_value({test_name, " ", kind, " tval"}, exp.tval, act.ex.tval);
        end
    endtask

    // ------------------------------------------------------------------
    // reference rules
    // ------------------------------------------------------------------
    // 0 byte, 1 halfword, 2 word
    function automatic int op_size(lsu_op_e o);
        if (o inside {LB, LBU, SB}) return 0;
        if (o inside {LH, LHU, SH}) return 1;
        return 2;
    endfunction

    function automatic logic is_misaligned(lsu_op_e o, logic [31:0] a);
        return (op_size(o) == 1 && a[0]) || (op_size(o) == 2 && a[1:0] != 2'b00);
    endfunction

    function automatic logic [31:0] load_value(lsu_op_e o, logic [31:0] a, logic [31:0] w);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*a[1:0] +: 8];
        h = w[16*a[1] +: 16];
        case (o)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'b0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'b0, h};
            default: return w;
        endcase
    endfunction

    function automatic logic [31:0] store_merge(lsu_op_e o, logic [31:0] a, logic [31:0] w,
                                                logic [31:0] d);
        logic [31:0] r;
        r = w;
        case (o)
            SB:      r[8*a[1:0] +: 8] = d[7:0];
            SH:      r[16*a[1] +: 16] = d[15:0];
            default: r = d;
        endcase
        return r;
    endfunction

    // byte address inside the 1 KiB model, aligned or forced misaligned
    function automatic logic [31:0] rand_addr(lsu_op_e o, logic aligned);
        logic [31:0] a;
        a = $urandom_range(1023);
        if (op_size(o) == 1) a[0] = !aligned;
        if (op_size(o) == 2) a[1:0] = aligned ? 2'd0 : 2'($urandom_range(3, 1));
        return a;
    endfunction

    // ------------------------------------------------------------------
    // stimulus, entered and left 1 ns after a rising edge
    // ------------------------------------------------------------------
    task automatic issue(lsu_op_e o, logic [31:0] addr, logic [31:0] data);
        logic [11:0] r;
        expect_t     exp;
        int          waited;
        r           = 12'($urandom());
        imm_i       = {{20{r[11]}}, r};
        operand_a_i = addr - imm_i;
        operand_b_i = data;
        op_i        = o;
        trans_id_i  = next_id;
        valid_i     = 1'b1;
        waited      = 0;
        @(negedge clk_i);
        while (!ready_o) begin
            waited++;
            if (waited > TIMEOUT) begin
                timeouts++;
                $display("timeout in %s: request was never accepted", test_name);
                finish_run();
            end
            @(negedge clk_i);
        end
        // in-order execution, so the model at acceptance is memory at grant
        exp          = '0;
        exp.trans_id = next_id;
        if (is_misaligned(o, addr)) begin
            exp.ex_valid = 1'b1;
            exp.cause    = (o inside {SB, SH, SW}) ? 4'd6 : 4'd4;
            exp.tval     = addr;
        end else if (o inside {SB, SH, SW}) begin
            ref_mem[addr[9:2]] = store_merge(o, addr, ref_mem[addr[9:2]], data);
        end else begin
            exp.data = load_value(o, addr, ref_mem[addr[9:2]]);
        end
        if (o inside {SB, SH, SW}) store_q.push_back(exp);
        else load_q.push_back(exp);
        next_id++;
        @(posedge clk_i);
        #1;
        valid_i = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(posedge clk_i);
        while (load_q.size() != 0 || store_q.size() != 0) begin
            waited++;
            if (waited > TIMEOUT) begin
                timeouts++;
                $display("timeout in %s: results still outstanding", test_name);
                finish_run();
            end
            @(posedge clk_i);
        end
        #1;
    endtask

    // ------------------------------------------------------------------
    // memory model and result monitor
    // ------------------------------------------------------------------
    always @(negedge clk_i) begin
        mem_hit = mem_req_o.req && mem_gnt_i;
        mem_cap = mem_req_o;
        if (mem_req_o.req && mem_req_o.addr >= MEM_WORDS) begin
            errors++;
            $display("memory request to word %h is outside the model", mem_req_o.addr);
        end
    end

    always @(posedge clk_i) begin
        #1;
        if (mem_hit && mem_cap.we) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_cap.be[b]) mem[mem_cap.addr[7:0]][8*b +: 8] = mem_cap.wdata[8*b +: 8];
            end
            write_count++;
        end
        // junk when no read answer is due
        mem_rdata_i = (mem_hit && !mem_cap.we) ? mem[mem_cap.addr[7:0]] : $urandom();
        mem_gnt_i   = !gnt_hold && ($urandom_range(99) < 60);
    end

    always @(negedge clk_i) begin
        if (rst_ni && load_res_o.valid) begin
            if (load_q.size() == 0) begin
                errors++;
                $display("load result id %0d arrived with no load outstanding",
                         load_res_o.trans_id);
            end else begin
                compare_result("load", load_q.pop_front(), load_res_o);
            end
        end
        if (rst_ni && store_res_o.valid) begin
            if (store_q.size() == 0) begin
                errors++;
                $display("store result id %0d arrived with no store outstanding",
                         store_res_o.trans_id);
            end else begin
                compare_result("store", store_q.pop_front(), store_res_o);
            end
        end
    end

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial begin
        void'($urandom(32'hfb34e85b));
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        flush_i     = 1'b0;
        valid_i     = 1'b0;
        operand_a_i = '0;
        imm_i       = '0;
        operand_b_i = '0;
        op_i        = LB;
        trans_id_i  = '0;
        mem_gnt_i   = 1'b0;
        mem_rdata_i = '0;
        gnt_hold    = 1'b1;
        mem_hit     = 1'b0;
        errors      = 0;
        timeouts    = 0;
        write_count = 0;
        next_id     = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = $urandom();
            ref_mem[i] = mem[i];
        end
        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        @(negedge clk_i);
        test_name = "reset";
        check_value("reset ready", 1, ready_o);
        check_value("reset mem req", 0, mem_req_o.req);
        check_value("reset load valid", 0, load_res_o.valid);
        check_value("reset store valid", 0, store_res_o.valid);
        gnt_hold = 1'b0;
        @(posedge clk_i);
        #1;

        test_name = "aligned";
        // stores and loads share the first 16 words so loads read back stored data
        repeat (40) begin
            op = lsu_op_e'($urandom_range(7, 5));
            issue(op, rand_addr(op, 1'b1) & 32'h3f, $urandom());
        end
        wait_idle();
        for (int i = 0; i < 60; i++) begin
            op = lsu_op_e'((i < 30) ? $urandom_range(7, 5) : $urandom_range(4, 0));
            issue(op, rand_addr(op, 1'b1) & 32'h3f, $urandom());
        end
        wait_idle();

        test_name = "misaligned";
        for (int i = 0; i < 20; i++) begin
            case ($urandom_range(4))
                0:       op = LH;
                1:       op = LHU;
                2:       op = LW;
                3:       op = SH;
                default: op = SW;
            endcase
            writes_before = write_count;
            issue(op, rand_addr(op, 1'b0), $urandom());
            // old word must still be there
            issue(LW, {operand_a_i + imm_i} & 32'hffff_fffc, 0);
            wait_idle();
            check_value("misaligned write count", writes_before, write_count);
        end

        test_name = "backpressure";
        @(negedge clk_i);
        gnt_hold = 1'b1;
        @(posedge clk_i);
        #1;
        issue(SW, rand_addr(SW, 1'b1), $urandom());
        issue(LW, rand_addr(LW, 1'b1), 0);
        @(negedge clk_i);
        check_value("backpressure ready after two", 0, ready_o);
        @(posedge clk_i);
        #1;
        fork
            begin
                repeat (20) @(posedge clk_i);
                gnt_hold = 1'b0;
            end
            begin
                issue(SH, rand_addr(SH, 1'b1), $urandom());
                issue(LBU, rand_addr(LBU, 1'b1), 0);
            end
        join
        wait_idle();

        test_name = "random";
        repeat (500) begin
            op = lsu_op_e'($urandom_range(7, 0));
            issue(op, rand_addr(op, $urandom_range(9) != 0), $urandom());
            if ($urandom_range(3) == 0) begin
                @(posedge clk_i);
                #1;
            end
        end
        wait_idle();
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_value($sformatf("random memory word %0d", i), ref_mem[i], mem[i]);
        end
        finish_run();
    end

endmodule

//--- verilog.f
+incdir+design
design/lsu_pkg.sv
design/lsu_agu.sv
design/lsu_req_buffer.sv
design/lsu_load_unit.sv
design/lsu_store_unit.sv
design/lsu_top.sv
testbench/tb_lsu.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - include_dirs:
      - design
    files:
      - design/lsu_pkg.sv
      - design/lsu_agu.sv
      - design/lsu_req_buffer.sv
      - design/lsu_load_unit.sv
      - design/lsu_store_unit.sv
      - design/lsu_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_lsu.sv
